// ==== tb.f ====
verilog/core_pkg.sv
verilog/op_pkg.sv
verilog/ex_mem_if.sv
verilog/ex_mem_reg.sv
verilog/branch_resolve.sv
verilog/data_mem_stage.sv
verilog/writeback_stage.sv
verilog/core_back_end.sv
bench/core_back_end_assert.sv
bench/core_back_end_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the back-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module core_back_end_tb

./obj_dir/Vcore_back_end_tb | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// ==== bench/core_back_end_tb.sv ====
`timescale 1ns/1ps

module core_back_end_tb;

    localparam int dm_words = 256;
    localparam int period   = 40;

    typedef struct {
        logic               en;
        logic               clear;
        core_pkg::pc_t      pc_4;
        core_pkg::imm16_t   imm16;
        logic               w_en;
        core_pkg::word_t    a;
        core_pkg::word_t    b;
        core_pkg::reg_idx_t idx;
        op_pkg::wtg_op_t    wtg;
        core_pkg::word_t    alu;
        op_pkg::dm_op_t     dm;
        logic               st;
        op_pkg::wb_sel_t    wb;
        logic               sys;
        core_pkg::pc_t      guess;
    } row_t;

    typedef struct {
        logic               redirect;
        core_pkg::pc_t      redirect_pc;
        logic               rf_w_en;
        core_pkg::reg_idx_t rf_w_idx;
        core_pkg::word_t    rf_w_data;
        logic               halted;
    } exp_t;

    logic clk, rst_n, en, clear, regfile_w_en, datamem_w_en, syscall_en;
    core_pkg::pc_t      pc_4, pc_guessed, redirect_pc;
    core_pkg::imm16_t   imm16;
    core_pkg::word_t    regfile_data_a, regfile_data_b, alu_data_res, rf_w_data;
    core_pkg::reg_idx_t regfile_req_w, rf_w_idx;
    op_pkg::wtg_op_t    wtg_op;
    op_pkg::dm_op_t     datamem_op;
    op_pkg::wb_sel_t    wb_sel;
    logic               redirect, rf_w_en, halted;

    row_t  rows[$];
    exp_t  exp_tab[$];
    string test_names[$];
    int    test_end[$];
    logic  built = 1'b0;
    int    err_count = 0;
    logic [31:0] lfsr_state = 32'd65896;

    // Reference state of the back end
    row_t               m_reg;
    logic               m_wb_en, m_halted;
    core_pkg::reg_idx_t m_wb_idx;
    core_pkg::word_t    m_wb_data;
    core_pkg::word_t    ref_mem [dm_words];

    core_back_end #(.dm_words(dm_words)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic core_pkg::word_t random_bits(int n);
        core_pkg::word_t res;
        logic            b;
        res = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            res = {res[30:0], b};
        end
        return res;
    endfunction

    function automatic row_t nop_row();
        row_t r;
        r = '{default: 0};
        r.en = 1'b1;
        return r;
    endfunction

    function automatic row_t alu_row(op_pkg::wb_sel_t sel, core_pkg::reg_idx_t idx,
                                     core_pkg::word_t alu, core_pkg::pc_t pc4, logic w_en);
        row_t r;
        r = nop_row();
        r.wb = sel;
        r.idx = idx;
        r.alu = alu;
        r.pc_4 = pc4;
        r.w_en = w_en;
        return r;
    endfunction

    function automatic row_t mem_row(op_pkg::dm_op_t op, logic st, core_pkg::word_t addr,
                                     core_pkg::word_t data, core_pkg::reg_idx_t idx);
        row_t r;
        r = alu_row(op_pkg::wb_mem, idx, addr, 32'h0, !st);
        r.dm = op;
        r.st = st;
        r.b = data;
        return r;
    endfunction

    function automatic row_t br_row(op_pkg::wtg_op_t op, core_pkg::word_t a,
                                    core_pkg::word_t b, core_pkg::imm16_t imm,
                                    core_pkg::pc_t guess);
        row_t r;
        r = alu_row(op_pkg::wb_alu, 5'd0, 32'h0040_0100, 32'h1000_0004, 1'b0);
        r.wtg = op;
        r.a = a;
        r.b = b;
        r.imm16 = imm;
        r.guess = guess;
        return r;
    endfunction

    function automatic core_pkg::pc_t real_next(row_t s);
        core_pkg::pc_t tgt;
        // Immediate counts instructions, four bytes each
        tgt = s.pc_4 + 32'(signed'(s.imm16)) * 4;
        case (s.wtg)
            op_pkg::wtg_beq:  return (s.a == s.b) ? tgt : s.pc_4;
            op_pkg::wtg_bne:  return (s.a != s.b) ? tgt : s.pc_4;
            op_pkg::wtg_jr:   return s.a;
            op_pkg::wtg_jump: return s.alu;
            default:          return s.pc_4;
        endcase
    endfunction

    function automatic core_pkg::word_t load_value(row_t s);
        core_pkg::word_t w;
        logic [1:0]      off;
        logic [15:0]     h;
        logic [7:0]      b;
        w = ref_mem[int'((s.alu >> 2) % dm_words)];
        off = s.alu[1:0];
        h = off[1] ? w[31:16] : w[15:0];
        b = w[8*off +: 8];
        case (s.dm)
            op_pkg::dm_half:  return {{16{h[15]}}, h};
            op_pkg::dm_uhalf: return {16'h0, h};
            op_pkg::dm_byte:  return {{24{b[7]}}, b};
            op_pkg::dm_ubyte: return {24'h0, b};
            default:          return w;
        endcase
    endfunction

    task automatic store_value(row_t s);
        int         widx;
        logic [1:0] off;
        widx = int'((s.alu >> 2) % dm_words);
        off = s.alu[1:0];
        case (s.dm)
            op_pkg::dm_half, op_pkg::dm_uhalf: begin
                if (off[1]) ref_mem[widx][31:16] = s.b[15:0];
                else ref_mem[widx][15:0] = s.b[15:0];
            end
            op_pkg::dm_byte, op_pkg::dm_ubyte: ref_mem[widx][8*off +: 8] = s.b[7:0];
            default: ref_mem[widx] = s.b;
        endcase
    endtask

    // One clock edge of the reference, returns what the outputs show after it
    task automatic model_edge(input row_t in, output exp_t e);
        logic redir;
        core_pkg::word_t wb_data;
        if (in.en) begin
            redir = (m_reg.wtg != op_pkg::wtg_none) && (real_next(m_reg) != m_reg.guess);
            case (m_reg.wb)
                op_pkg::wb_mem: wb_data = load_value(m_reg);
                op_pkg::wb_pc4: wb_data = m_reg.pc_4;
                default:        wb_data = m_reg.alu;
            endcase
            if (m_reg.st) store_value(m_reg);
            m_wb_en = m_reg.w_en;
            m_wb_idx = m_reg.idx;
            m_wb_data = wb_data;
            if (m_reg.sys) m_halted = 1'b1;
            if (in.clear || redir) begin
                m_reg = '{default: 0};
            end else begin
                m_reg = in;
            end
        end
        e.redirect = (m_reg.wtg != op_pkg::wtg_none) && (real_next(m_reg) != m_reg.guess);
        e.redirect_pc = real_next(m_reg);
        e.rf_w_en = m_wb_en;
        e.rf_w_idx = m_wb_idx;
        e.rf_w_data = m_wb_data;
        e.halted = m_halted;
    endtask

    task automatic end_test(string name);
        rows.push_back(nop_row());
        rows.push_back(nop_row());
        test_names.push_back(name);
        test_end.push_back(rows.size() - 1);
    endtask

    task automatic build_table();
        row_t            r;
        core_pkg::word_t addr;
        core_pkg::word_t addrs[$];
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd3, 32'hdead_beef, 32'h0000_0104, 1'b1));
        rows.push_back(alu_row(op_pkg::wb_pc4, 5'd31, 32'h1234_5678, 32'h0000_0108, 1'b1));
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd4, 32'h0bad_f00d, 32'h0000_010c, 1'b0));
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd7, 32'h0000_0007, 32'h0000_0110, 1'b1));
        end_test("alu_link");
        rows.push_back(mem_row(op_pkg::dm_word, 1'b1, 32'h40, 32'h8899_aabb, 5'd0));
        rows.push_back(mem_row(op_pkg::dm_word, 1'b1, 32'h44, 32'h0102_0304, 5'd0));
        rows.push_back(mem_row(op_pkg::dm_half, 1'b1, 32'h46, 32'hffff_f00d, 5'd0));
        rows.push_back(mem_row(op_pkg::dm_byte, 1'b1, 32'h41, 32'h0000_007e, 5'd0));
        rows.push_back(mem_row(op_pkg::dm_ubyte, 1'b1, 32'h43, 32'h0000_0085, 5'd0));
        rows.push_back(mem_row(op_pkg::dm_word, 1'b0, 32'h40, 32'h0, 5'd1));
        rows.push_back(mem_row(op_pkg::dm_half, 1'b0, 32'h42, 32'h0, 5'd2));
        rows.push_back(mem_row(op_pkg::dm_uhalf, 1'b0, 32'h42, 32'h0, 5'd3));
        rows.push_back(mem_row(op_pkg::dm_byte, 1'b0, 32'h43, 32'h0, 5'd4));
        rows.push_back(mem_row(op_pkg::dm_ubyte, 1'b0, 32'h43, 32'h0, 5'd5));
        rows.push_back(mem_row(op_pkg::dm_byte, 1'b0, 32'h41, 32'h0, 5'd6));
        rows.push_back(mem_row(op_pkg::dm_half, 1'b0, 32'h46, 32'h0, 5'd7));
        rows.push_back(mem_row(op_pkg::dm_uhalf, 1'b0, 32'h47, 32'h0, 5'd8));
        rows.push_back(mem_row(op_pkg::dm_word, 1'b0, 32'h45, 32'h0, 5'd9));
        end_test("load_store");
        rows.push_back(br_row(op_pkg::wtg_beq, 32'd5, 32'd5, 16'h0010, 32'h1000_0044));
        rows.push_back(br_row(op_pkg::wtg_beq, 32'd5, 32'd6, 16'h0010, 32'h1000_0044));
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd9, 32'h0000_0009, 32'h0, 1'b1));
        rows.push_back(br_row(op_pkg::wtg_bne, 32'd1, 32'd2, 16'hfff0, 32'h1000_0004));
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd10, 32'h0000_000a, 32'h0, 1'b1));
        rows.push_back(br_row(op_pkg::wtg_bne, 32'd3, 32'd3, 16'hfff0, 32'h1000_0004));
        rows.push_back(br_row(op_pkg::wtg_jr, 32'h0040_2000, 32'd0, 16'h0, 32'h0040_2000));
        rows.push_back(br_row(op_pkg::wtg_jr, 32'h0040_2000, 32'd0, 16'h0, 32'h1000_0004));
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd11, 32'h0000_000b, 32'h0, 1'b1));
        rows.push_back(br_row(op_pkg::wtg_jump, 32'd0, 32'd0, 16'h0, 32'h0040_0100));
        rows.push_back(br_row(op_pkg::wtg_jump, 32'd0, 32'd0, 16'h0, 32'h0000_0000));
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd12, 32'h0000_000c, 32'h0, 1'b1));
        end_test("branch");
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd5, 32'h5555_aaaa, 32'h0, 1'b1));
        // Write-back shows an enabled write while the pipeline stalls
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd6, 32'h6666_6666, 32'h0, 1'b1));
        r = alu_row(op_pkg::wb_alu, 5'd8, 32'h8888_8888, 32'h0, 1'b1);
        r.en = 1'b0;
        rows.push_back(r);
        rows.push_back(r);
        rows.push_back(mem_row(op_pkg::dm_word, 1'b1, 32'h80, 32'hcafe_0001, 5'd0));
        r = mem_row(op_pkg::dm_word, 1'b1, 32'h80, 32'hcafe_0002, 5'd0);
        r.en = 1'b0;
        rows.push_back(r);
        r.en = 1'b1;
        r.clear = 1'b1;
        rows.push_back(r);
        r = br_row(op_pkg::wtg_jump, 32'd0, 32'd0, 16'h0, 32'h0);
        r.clear = 1'b1;
        rows.push_back(r);
        rows.push_back(mem_row(op_pkg::dm_word, 1'b0, 32'h80, 32'h0, 5'd13));
        end_test("stall_flush");
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd14, 32'h0000_000e, 32'h0, 1'b1));
        r = nop_row();
        r.sys = 1'b1;
        rows.push_back(r);
        rows.push_back(alu_row(op_pkg::wb_alu, 5'd15, 32'h0000_000f, 32'h0, 1'b1));
        end_test("halt");
        for (int i = 0; i < 64; i++) begin
            addr = random_bits(12) << 2;
            addrs.push_back(addr);
            rows.push_back(mem_row(op_pkg::dm_word, 1'b1, addr, random_bits(32), 5'd0));
        end
        for (int i = 0; i < 64; i++) begin
            rows.push_back(mem_row(op_pkg::dm_word, 1'b0, addrs[i], 32'h0, 5'(i % 31 + 1)));
        end
        end_test("random_sweep");
    endtask

    task automatic drive(row_t r);
        en = r.en;
        clear = r.clear;
        pc_4 = r.pc_4;
        imm16 = r.imm16;
        regfile_w_en = r.w_en;
        regfile_data_a = r.a;
        regfile_data_b = r.b;
        regfile_req_w = r.idx;
        wtg_op = r.wtg;
        alu_data_res = r.alu;
        datamem_op = r.dm;
        datamem_w_en = r.st;
        wb_sel = r.wb;
        syscall_en = r.sys;
        pc_guessed = r.guess;
    endtask

    task automatic check_outputs(exp_t e, int row);
        assert (redirect === e.redirect) else begin
            $display("error: row %0d redirect = %h, expected %h", row, redirect, e.redirect);
            err_count++;
        end
        assert (redirect_pc === e.redirect_pc) else begin
            $display("error: row %0d redirect_pc = %h, expected %h", row, redirect_pc,
                     e.redirect_pc);
            err_count++;
        end
        assert (rf_w_en === e.rf_w_en) else begin
            $display("error: row %0d rf_w_en = %h, expected %h", row, rf_w_en, e.rf_w_en);
            err_count++;
        end
        assert (!e.rf_w_en || (rf_w_idx === e.rf_w_idx && rf_w_data === e.rf_w_data)) else begin
            $display("error: row %0d rf_w_idx/rf_w_data = %h/%h, expected %h/%h", row,
                     rf_w_idx, rf_w_data, e.rf_w_idx, e.rf_w_data);
            err_count++;
        end
        assert (halted === e.halted) else begin
            $display("error: row %0d halted = %h, expected %h", row, halted, e.halted);
            err_count++;
        end
    endtask

    // Watchdog sized from the table length
    initial begin
        int timeout_ns;
        wait (built);
        timeout_ns = 2 * rows.size() * period + 1000;
        #(timeout_ns);
        $display("watchdog: simulation did not finish within %0d ns", timeout_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        exp_t e;
        int   t;
        int   test_errs;
        int   tests_ok;
        int   tests_bad;
        t = 0;
        test_errs = 0;
        tests_ok = 0;
        tests_bad = 0;
        rst_n = 1'b0;
        drive('{default: 0});
        build_table();
        m_reg = '{default: 0};
        m_wb_en = 1'b0;
        m_halted = 1'b0;
        m_wb_idx = '0;
        m_wb_data = '0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        foreach (rows[i]) begin
            model_edge(rows[i], e);
            exp_tab.push_back(e);
        end
        built = 1'b1;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        for (int r = 0; r < rows.size(); r++) begin
            drive(rows[r]);
            @(posedge clk);
            #1;
            check_outputs(exp_tab[r], r);
            if (r == test_end[t]) begin
                $display("test %s: %0d errors", test_names[t], err_count - test_errs);
                if (err_count == test_errs) tests_ok++;
                else tests_bad++;
                test_errs = err_count;
                t++;
            end
            #1;
        end
        // halted must clear under reset
        rst_n = 1'b0;
        #1;
        assert (halted === 1'b0) else begin
            $display("error: halted = %h after reset, expected 0", halted);
            err_count++;
        end
        $display("test halt_reset: %0d errors", err_count - test_errs);
        if (err_count == test_errs) tests_ok++;
        else tests_bad++;
        $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== bench/core_back_end_assert.sv ====
`timescale 1ns/1ps

module core_back_end_assert (
    input logic clk,
    input logic rst_n,
    input logic en,
    input logic clear,
    input logic redirect,
    input logic rf_w_en,
    input logic halted
);

    logic seen_capture;

    // Set once the stage register has taken an instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_capture <= 1'b0;
        end else if (en) begin
            seen_capture <= 1'b1;
        end
    end

    // A flushed register holds a bubble
    no_redirect_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (en && (clear || redirect)) |=> !redirect)
        else $error("redirect high in the cycle after a flush");

    no_write_before_capture: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_capture |-> !rf_w_en)
        else $error("rf_w_en high before any instruction was captured");

    halted_is_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(halted))
        else $error("halted fell while out of reset");

endmodule

bind core_back_end core_back_end_assert assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (en),
    .clear    (clear),
    .redirect (redirect),
    .rf_w_en  (rf_w_en),
    .halted   (halted)
);

// ==== verilog/core_back_end.sv ====
`timescale 1ns/1ps

module core_back_end #(
    parameter int dm_words = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               clear,
    input  core_pkg::pc_t      pc_4,
    input  core_pkg::imm16_t   imm16,
    input  logic               regfile_w_en,
    input  core_pkg::word_t    regfile_data_a,
    input  core_pkg::word_t    regfile_data_b,
    input  core_pkg::reg_idx_t regfile_req_w,
    input  op_pkg::wtg_op_t    wtg_op,
    input  core_pkg::word_t    alu_data_res,
    input  op_pkg::dm_op_t     datamem_op,
    input  logic               datamem_w_en,
    input  op_pkg::wb_sel_t    wb_sel,
    input  logic               syscall_en,
    input  core_pkg::pc_t      pc_guessed,
    output logic               redirect,
    output core_pkg::pc_t      redirect_pc,
    output logic               rf_w_en,
    output core_pkg::reg_idx_t rf_w_idx,
    output core_pkg::word_t    rf_w_data,
    output logic               halted
);

    logic            flush;
    core_pkg::word_t load_data;

    ex_mem_if ex_mem_bus ();

    // The instruction in execute is wrong-path once a branch mispredicts
    assign flush = clear | redirect;

    ex_mem_reg ex_mem_reg_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .clear          (flush),
        .pc_4           (pc_4),
        .imm16          (imm16),
        .regfile_w_en   (regfile_w_en),
        .regfile_data_a (regfile_data_a),
        .regfile_data_b (regfile_data_b),
        .regfile_req_w  (regfile_req_w),
        .wtg_op         (wtg_op),
        .alu_data_res   (alu_data_res),
        .datamem_op     (datamem_op),
        .datamem_w_en   (datamem_w_en),
        .wb_sel         (wb_sel),
        .syscall_en     (syscall_en),
        .pc_guessed     (pc_guessed),
        .bus            (ex_mem_bus.reg_side)
    );

    branch_resolve branch_resolve_i (
        .bus         (ex_mem_bus.stage_side),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    data_mem_stage #(
        .dm_words (dm_words)
    ) data_mem_stage_i (
        .clk       (clk),
        .en        (en),
        .bus       (ex_mem_bus.stage_side),
        .load_data (load_data)
    );

    writeback_stage writeback_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .bus       (ex_mem_bus.stage_side),
        .load_data (load_data),
        .rf_w_en   (rf_w_en),
        .rf_w_idx  (rf_w_idx),
        .rf_w_data (rf_w_data),
        .halted    (halted)
    );

endmodule

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    ex_mem_if.stage_side       bus,
    input  core_pkg::word_t    load_data,
    output logic               rf_w_en,
    output core_pkg::reg_idx_t rf_w_idx,
    output core_pkg::word_t    rf_w_data,
    output logic               halted
);

    core_pkg::word_t wb_data;

    // Register file write data source
    always_comb begin
        case (bus.wb_sel)
            op_pkg::wb_mem: begin
                wb_data = load_data;
            end
            op_pkg::wb_pc4: begin
                // Link value for jal style instructions
                wb_data = bus.pc_4;
            end
            default: begin
                wb_data = bus.alu_data_res;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_w_en <= 1'b0;
            halted  <= 1'b0;
        end else if (en) begin
            rf_w_en <= bus.regfile_w_en;
            // Sticky until reset
            if (bus.syscall_en) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rf_w_idx  <= bus.regfile_req_w;
            rf_w_data <= wb_data;
        end
    end

endmodule

// ==== verilog/data_mem_stage.sv ====
`timescale 1ns/1ps

module data_mem_stage #(
    parameter int dm_words = 256
) (
    input  logic            clk,
    input  logic            en,
    ex_mem_if.stage_side    bus,
    output core_pkg::word_t load_data
);

    localparam int idx_bits = $clog2(dm_words);

    core_pkg::word_t                     mem [dm_words];
    logic [idx_bits-1:0]                 word_idx;
    logic [core_pkg::byte_off_bits-1:0]  byte_off;
    logic [core_pkg::word_bytes-1:0]     lane_en;
    core_pkg::word_t                     wr_word;
    core_pkg::word_t                     rd_word;
    logic [7:0]                          rd_byte;
    logic [15:0]                         rd_half;

    // Upper address bits wrap modulo the depth
    assign word_idx = bus.alu_data_res[idx_bits+core_pkg::byte_off_bits-1:
                                       core_pkg::byte_off_bits];
    assign byte_off = bus.alu_data_res[core_pkg::byte_off_bits-1:0];

    // Store data replicated over all lanes, lane_en picks the ones written
    always_comb begin
        case (bus.datamem_op)
            op_pkg::dm_half, op_pkg::dm_uhalf: begin
                wr_word = {2{bus.regfile_data_b[15:0]}};
                lane_en = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            op_pkg::dm_byte, op_pkg::dm_ubyte: begin
                wr_word = {4{bus.regfile_data_b[7:0]}};
                lane_en = 4'b0001 << byte_off;
            end
            default: begin
                wr_word = bus.regfile_data_b;
                lane_en = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en && bus.datamem_w_en) begin
            for (int i = 0; i < core_pkg::word_bytes; i++) begin
                if (lane_en[i]) begin
                    mem[word_idx][8*i +: 8] <= wr_word[8*i +: 8];
                end
            end
        end
    end

    // Little-endian lanes, misaligned low bits are ignored
    assign rd_word = mem[word_idx];
    assign rd_byte = rd_word[{byte_off, 3'b000} +: 8];
    assign rd_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (bus.datamem_op)
            op_pkg::dm_half: begin
                load_data = {{16{rd_half[15]}}, rd_half};
            end
            op_pkg::dm_uhalf: begin
                load_data = {16'h0000, rd_half};
            end
            op_pkg::dm_byte: begin
                load_data = {{24{rd_byte[7]}}, rd_byte};
            end
            op_pkg::dm_ubyte: begin
                load_data = {24'h000000, rd_byte};
            end
            default: begin
                load_data = rd_word;
            end
        endcase
    end

endmodule

// ==== verilog/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
    ex_mem_if.stage_side  bus,
    output logic          redirect,
    output core_pkg::pc_t redirect_pc
);

    core_pkg::pc_t branch_off;
    core_pkg::pc_t branch_tgt;
    core_pkg::pc_t real_next;
    logic          operands_eq;

    // Word offset from the immediate, relative to pc + 4
    assign branch_off  = {{14{bus.imm16[15]}}, bus.imm16, 2'b00};
    assign branch_tgt  = bus.pc_4 + branch_off;
    assign operands_eq = (bus.regfile_data_a == bus.regfile_data_b);

    always_comb begin
        real_next = bus.pc_4;
        case (bus.wtg_op)
            op_pkg::wtg_beq: begin
                if (operands_eq) begin
                    real_next = branch_tgt;
                end
            end
            op_pkg::wtg_bne: begin
                if (!operands_eq) begin
                    real_next = branch_tgt;
                end
            end
            op_pkg::wtg_jr: begin
                real_next = bus.regfile_data_a;
            end
            op_pkg::wtg_jump: begin
                // Jump target is formed by the ALU in execute
                real_next = bus.alu_data_res;
            end
            default: begin
                real_next = bus.pc_4;
            end
        endcase
    end

    // Plain instructions never redirect, whatever was guessed for them
    assign redirect    = (bus.wtg_op != op_pkg::wtg_none) && (real_next != bus.pc_guessed);
    assign redirect_pc = real_next;

endmodule

// ==== verilog/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               clear,
    input  core_pkg::pc_t      pc_4,
    input  core_pkg::imm16_t   imm16,
    input  logic               regfile_w_en,
    input  core_pkg::word_t    regfile_data_a,
    input  core_pkg::word_t    regfile_data_b,
    input  core_pkg::reg_idx_t regfile_req_w,
    input  op_pkg::wtg_op_t    wtg_op,
    input  core_pkg::word_t    alu_data_res,
    input  op_pkg::dm_op_t     datamem_op,
    input  logic               datamem_w_en,
    input  op_pkg::wb_sel_t    wb_sel,
    input  logic               syscall_en,
    input  core_pkg::pc_t      pc_guessed,
    ex_mem_if.reg_side         bus
);

    // Flush only takes effect on an enabled edge, a stalled branch keeps its redirect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || (en && clear)) begin
            bus.pc_4           <= '0;
            bus.imm16          <= '0;
            bus.regfile_w_en   <= 1'b0;
            bus.regfile_data_a <= '0;
            bus.regfile_data_b <= '0;
            bus.regfile_req_w  <= '0;
            bus.wtg_op         <= op_pkg::wtg_none;
            bus.alu_data_res   <= '0;
            bus.datamem_op     <= op_pkg::dm_word;
            bus.datamem_w_en   <= 1'b0;
            bus.wb_sel         <= op_pkg::wb_alu;
            bus.syscall_en     <= 1'b0;
            bus.pc_guessed     <= '0;
        end else if (en) begin
            bus.pc_4           <= pc_4;
            bus.imm16          <= imm16;
            bus.regfile_w_en   <= regfile_w_en;
            bus.regfile_data_a <= regfile_data_a;
            bus.regfile_data_b <= regfile_data_b;
            bus.regfile_req_w  <= regfile_req_w;
            bus.wtg_op         <= wtg_op;
            bus.alu_data_res   <= alu_data_res;
            bus.datamem_op     <= datamem_op;
            bus.datamem_w_en   <= datamem_w_en;
            bus.wb_sel         <= wb_sel;
            bus.syscall_en     <= syscall_en;
            bus.pc_guessed     <= pc_guessed;
        end
    end

endmodule

// ==== verilog/ex_mem_if.sv ====
`timescale 1ns/1ps

// Fields of one executed instruction held between execute and memory
interface ex_mem_if;

    core_pkg::pc_t      pc_4;
    core_pkg::imm16_t   imm16;
    logic               regfile_w_en;
    core_pkg::word_t    regfile_data_a;
    core_pkg::word_t    regfile_data_b;
    core_pkg::reg_idx_t regfile_req_w;
    op_pkg::wtg_op_t    wtg_op;
    core_pkg::word_t    alu_data_res;
    op_pkg::dm_op_t     datamem_op;
    logic               datamem_w_en;
    op_pkg::wb_sel_t    wb_sel;
    logic               syscall_en;
    core_pkg::pc_t      pc_guessed;

    // Stage register drives the fields
    modport reg_side (
        output pc_4, imm16, regfile_w_en, regfile_data_a, regfile_data_b,
        output regfile_req_w, wtg_op, alu_data_res, datamem_op, datamem_w_en,
        output wb_sel, syscall_en, pc_guessed
    );

    // Memory and write-back logic only look at them
    modport stage_side (
        input pc_4, imm16, regfile_w_en, regfile_data_a, regfile_data_b,
        input regfile_req_w, wtg_op, alu_data_res, datamem_op, datamem_w_en,
        input wb_sel, syscall_en, pc_guessed
    );

endinterface

// ==== verilog/op_pkg.sv ====
// Control op codes carried from execute into the memory and write-back stages
package op_pkg;

    // Branch op ("where to go")
    typedef logic [2:0] wtg_op_t;

    // A zero code is the bubble, so no redirect comes out of a cleared register
    localparam wtg_op_t wtg_none = 3'd0;
    localparam wtg_op_t wtg_beq  = 3'd1;
    localparam wtg_op_t wtg_bne  = 3'd2;
    localparam wtg_op_t wtg_jr   = 3'd3;
    localparam wtg_op_t wtg_jump = 3'd4;

    // Data memory access size and extension
    typedef logic [2:0] dm_op_t;

    localparam dm_op_t dm_word  = 3'd0;
    localparam dm_op_t dm_half  = 3'd1;
    localparam dm_op_t dm_uhalf = 3'd2;
    localparam dm_op_t dm_byte  = 3'd3;
    localparam dm_op_t dm_ubyte = 3'd4;

    // Source of the register file write data
    typedef logic [1:0] wb_sel_t;

    localparam wb_sel_t wb_alu = 2'd0;
    localparam wb_sel_t wb_mem = 2'd1;
    localparam wb_sel_t wb_pc4 = 2'd2;

endpackage

// ==== verilog/core_pkg.sv ====
// Widths shared by every stage of the back end
package core_pkg;

    // Data word as held in registers and data memory
    typedef logic [31:0] word_t;

    // Byte address of an instruction
    typedef logic [31:0] pc_t;

    // Register file index
    typedef logic [4:0] reg_idx_t;

    // Raw 16-bit immediate from the instruction word
    typedef logic [15:0] imm16_t;

    // Bytes per data word
    localparam int word_bytes = 4;

    // Byte offset bits inside a word
    localparam int byte_off_bits = 2;

endpackage
